/* hw/pipeDefsPkg.sv */
// pipeline control types shared by the memory stage blocks
package pipeDefsPkg;

    // two instructions per cycle, slot 1 older than slot 0
    localparam int numSlots = 2;

    // width of a memory access
    // encodings follow the decode stage msize field
    typedef enum logic [1:0] {
        // one byte, any offset
        sizeByte = 2'b00,
        // two bytes, offset 0 or 2
        sizeHalf = 2'b01,
        // full word, offset 0
        sizeWord = 2'b10
    } accessSize_t;

    // control class of a slot as seen by the memory stage
    typedef enum logic [1:0] {
        // ordinary instruction
        ctlNone      = 2'b00,
        // trap raised somewhere upstream
        ctlException = 2'b01,
        // return from exception
        ctlEret      = 2'b10
    } ctlClass_t;

    // destination register index width, 32 GPRs
    localparam int regIdxWidth = 5;

    // low byte-offset bits of an address
    localparam int offsetWidth = 2;

endpackage

/* hw/busDefsPkg.sv */
// data bus widths and byte strobe between the stage and the data RAM
package busDefsPkg;

    // bits per data word
    localparam int dataWidth = 32;

    // bits per byte lane
    localparam int laneWidth = 8;

    // lanes per word, one strobe bit each
    localparam int numLanes = dataWidth / laneWidth;

    // plain data word on the bus
    typedef logic [dataWidth-1:0] word_t;

    // byte write enables
    // bit n covers bits 8n+7 down to 8n
    typedef logic [numLanes-1:0] strobe_t;

    // single byte lane
    typedef logic [laneWidth-1:0] lane_t;

    // halfword, two lanes
    typedef logic [2*laneWidth-1:0] half_t;

endpackage

/* hw/storeAlign.sv */
`timescale 1ns/100ps

module storeAlign (
    input  busDefsPkg::word_t                       storeData,
    input  pipeDefsPkg::accessSize_t                size,
    input  logic [pipeDefsPkg::offsetWidth-1:0]     addrLow,
    output busDefsPkg::word_t                       laneData,
    output busDefsPkg::strobe_t                     strobe
);

    import pipeDefsPkg::*;
    import busDefsPkg::*;

    // low byte and low halfword of the register value
    lane_t storeByte;
    half_t storeHalf;

    assign storeByte = storeData[laneWidth-1:0];
    assign storeHalf = storeData[2*laneWidth-1:0];

    always_comb begin
        unique case (size)
            sizeByte: begin
                // copy into every lane, strobe picks the real one
                laneData = {numLanes{storeByte}};
                strobe   = strobe_t'(1) << addrLow;
            end
            sizeHalf: begin
                laneData = {2{storeHalf}};
                // aligned halfword, bit 1 picks upper or lower pair
                strobe   = addrLow[1] ? 4'b1100 : 4'b0011;
            end
            sizeWord: begin
                laneData = storeData;
                strobe   = '1;
            end
            default: begin
                // unused encoding, behave as a word
                laneData = storeData;
                strobe   = '1;
            end
        endcase
    end

endmodule

/* hw/loadExtract.sv */
`timescale 1ns/100ps

module loadExtract (
    input  busDefsPkg::word_t                       readData,
    input  pipeDefsPkg::accessSize_t                size,
    input  logic [pipeDefsPkg::offsetWidth-1:0]     addrLow,
    input  logic                                    loadSigned,
    output busDefsPkg::word_t                       loadData
);

    import pipeDefsPkg::*;
    import busDefsPkg::*;

    // addressed byte and halfword shifted down to bit 0
    lane_t loadByte;
    half_t loadHalf;

    // byte lane select by offset
    always_comb begin
        unique case (addrLow)
            2'd0: loadByte = readData[7:0];
            2'd1: loadByte = readData[15:8];
            2'd2: loadByte = readData[23:16];
            default: loadByte = readData[31:24];
        endcase
    end

    // aligned halfword, bit 0 of the offset ignored
    assign loadHalf = addrLow[1] ? readData[31:16] : readData[15:0];

    always_comb begin
        unique case (size)
            sizeByte: begin
                // replicate the top bit for lb, zeros for lbu
                loadData = {{(dataWidth-laneWidth){loadSigned && loadByte[laneWidth-1]}},
                            loadByte};
            end
            sizeHalf: begin
                loadData = {{(dataWidth-2*laneWidth){loadSigned && loadHalf[2*laneWidth-1]}},
                            loadHalf};
            end
            default: begin
                // word load, nothing to extend
                loadData = readData;
            end
        endcase
    end

endmodule

/* hw/dataRam.sv */
`timescale 1ns/100ps

module dataRam #(
    parameter int addrWidth = 8
) (
    input  logic                            clk,
    input  logic [1:0]                      reqValid,
    input  logic [1:0]                      reqWrite,
    input  logic [1:0][addrWidth-1:0]       wordAddr,
    input  busDefsPkg::word_t [1:0]         writeData,
    input  busDefsPkg::strobe_t [1:0]       strobe,
    output busDefsPkg::word_t [1:0]         readData
);

    import busDefsPkg::*;

    localparam int depth = 2 ** addrWidth;

    // word array, no reset on contents
    word_t mem [depth];

    // per-port write enable
    logic [1:0] writeEn;
    // per-port read enable
    logic [1:0] readEn;

    for (genvar p = 0; p < 2; p++) begin : genEn
        assign writeEn[p] = reqValid[p] && reqWrite[p];
        assign readEn[p]  = reqValid[p] && !reqWrite[p];
    end

    // registered reads
    // nonblocking read sees the array before this edge's writes
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (readEn[p]) begin
                readData[p] <= mem[wordAddr[p]];
            end
        end
    end

    // byte writes
    // port 1 (older slot) first, port 0 after it so younger bytes win
    always_ff @(posedge clk) begin
        for (int p = 1; p >= 0; p--) begin
            if (writeEn[p]) begin
                for (int b = 0; b < numLanes; b++) begin
                    if (strobe[p][b]) begin
                        mem[wordAddr[p]][b*laneWidth +: laneWidth] <=
                            writeData[p][b*laneWidth +: laneWidth];
                    end
                end
            end
        end
    end

endmodule

/* hw/memStage.sv */
`timescale 1ns/100ps

module memStage (
    input  logic                                                    clk,
    input  logic                                                    rstN,
    input  logic [pipeDefsPkg::numSlots-1:0]                        slotValid,
    input  logic [pipeDefsPkg::numSlots-1:0]                        isLoad,
    input  logic [pipeDefsPkg::numSlots-1:0]                        isStore,
    input  logic [pipeDefsPkg::numSlots-1:0]                        loadSigned,
    input  pipeDefsPkg::accessSize_t [pipeDefsPkg::numSlots-1:0]    size,
    input  logic [pipeDefsPkg::numSlots-1:0][pipeDefsPkg::offsetWidth-1:0] addrLow,
    input  logic [pipeDefsPkg::numSlots-1:0][pipeDefsPkg::regIdxWidth-1:0] rdst,
    input  pipeDefsPkg::ctlClass_t [pipeDefsPkg::numSlots-1:0]      ctl,
    input  busDefsPkg::strobe_t [pipeDefsPkg::numSlots-1:0]         alignedStrobe,
    output logic                                                    excp,
    output logic [pipeDefsPkg::numSlots-1:0]                        reqValid,
    output logic [pipeDefsPkg::numSlots-1:0]                        reqWrite,
    output busDefsPkg::strobe_t [pipeDefsPkg::numSlots-1:0]         reqStrobe,
    output logic [pipeDefsPkg::numSlots-1:0]                        wbValid,
    output logic [pipeDefsPkg::numSlots-1:0][pipeDefsPkg::regIdxWidth-1:0] wbRdst,
    output pipeDefsPkg::accessSize_t [pipeDefsPkg::numSlots-1:0]    wbSize,
    output logic [pipeDefsPkg::numSlots-1:0]                        wbSigned,
    output logic [pipeDefsPkg::numSlots-1:0][pipeDefsPkg::offsetWidth-1:0] wbAddrLow
);

    import pipeDefsPkg::*;

    // valid slot whose own class is exception or eret
    logic [numSlots-1:0] isTrap;
    // slot allowed to touch memory this cycle
    logic [numSlots-1:0] live;
    // live load that owes a writeback next cycle
    logic [numSlots-1:0] loadLive;

    // trap detect per slot, eret counts the same as an exception here
    for (genvar i = 0; i < numSlots; i++) begin : genTrap
        assign isTrap[i] = slotValid[i] &&
                           (ctl[i] == ctlException || ctl[i] == ctlEret);
    end

    // older slot is never squashed by the younger one
    assign live[1] = slotValid[1] && (ctl[1] == ctlNone);

    // younger slot dies behind a trapping older slot
    assign live[0] = slotValid[0] && (ctl[0] == ctlNone) && !isTrap[1];

    // either slot trapping flags the stage in the same cycle
    assign excp = |isTrap;

    // request side, same cycle as the slot inputs
    for (genvar i = 0; i < numSlots; i++) begin : genReq
        // store wins if decode ever sets both
        assign reqWrite[i]  = live[i] && isStore[i];
        assign loadLive[i]  = live[i] && isLoad[i] && !isStore[i];
        assign reqValid[i]  = reqWrite[i] || loadLive[i];
        // loads never carry byte enables
        assign reqStrobe[i] = reqWrite[i] ? alignedStrobe[i] : '0;
    end

    // writeback valid, one cycle behind the load request
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= '0;
        end else begin
            wbValid <= loadLive;
        end
    end

    // load metadata for the extractor
    // only captured for live loads, otherwise held
    always_ff @(posedge clk) begin
        for (int i = 0; i < numSlots; i++) begin
            if (loadLive[i]) begin
                wbRdst[i]    <= rdst[i];
                wbSize[i]    <= size[i];
                wbSigned[i]  <= loadSigned[i];
                wbAddrLow[i] <= addrLow[i];
            end
        end
    end

endmodule

/* hw/memSubsystem.sv */
`timescale 1ns/100ps

module memSubsystem #(
    parameter int addrWidth = 8
) (
    input  logic                                                    clk,
    input  logic                                                    rstN,
    input  logic [pipeDefsPkg::numSlots-1:0]                        slotValid,
    input  logic [pipeDefsPkg::numSlots-1:0]                        isLoad,
    input  logic [pipeDefsPkg::numSlots-1:0]                        isStore,
    input  logic [pipeDefsPkg::numSlots-1:0]                        loadSigned,
    input  pipeDefsPkg::accessSize_t [pipeDefsPkg::numSlots-1:0]    size,
    input  busDefsPkg::word_t [pipeDefsPkg::numSlots-1:0]           addr,
    input  busDefsPkg::word_t [pipeDefsPkg::numSlots-1:0]           storeData,
    input  logic [pipeDefsPkg::numSlots-1:0][pipeDefsPkg::regIdxWidth-1:0] rdst,
    input  pipeDefsPkg::ctlClass_t [pipeDefsPkg::numSlots-1:0]      ctl,
    output logic                                                    excp,
    output logic [pipeDefsPkg::numSlots-1:0]                        wbValid,
    output logic [pipeDefsPkg::numSlots-1:0][pipeDefsPkg::regIdxWidth-1:0] wbRdst,
    output busDefsPkg::word_t [pipeDefsPkg::numSlots-1:0]           wbData
);

    import pipeDefsPkg::*;
    import busDefsPkg::*;

    // byte offset and word index of each slot address
    logic [numSlots-1:0][offsetWidth-1:0] addrLow;
    logic [numSlots-1:0][addrWidth-1:0]   wordAddr;

    // store aligner outputs
    word_t [numSlots-1:0]   laneData;
    strobe_t [numSlots-1:0] alignedStrobe;

    // RAM request from the control block
    logic [numSlots-1:0]    reqValid;
    logic [numSlots-1:0]    reqWrite;
    strobe_t [numSlots-1:0] reqStrobe;

    // registered read data and load metadata
    word_t [numSlots-1:0]                 readData;
    accessSize_t [numSlots-1:0]           wbSize;
    logic [numSlots-1:0]                  wbSigned;
    logic [numSlots-1:0][offsetWidth-1:0] wbAddrLow;

    memStage stage_i (
        .clk           (clk),
        .rstN          (rstN),
        .slotValid     (slotValid),
        .isLoad        (isLoad),
        .isStore       (isStore),
        .loadSigned    (loadSigned),
        .size          (size),
        .addrLow       (addrLow),
        .rdst          (rdst),
        .ctl           (ctl),
        .alignedStrobe (alignedStrobe),
        .excp          (excp),
        .reqValid      (reqValid),
        .reqWrite      (reqWrite),
        .reqStrobe     (reqStrobe),
        .wbValid       (wbValid),
        .wbRdst        (wbRdst),
        .wbSize        (wbSize),
        .wbSigned      (wbSigned),
        .wbAddrLow     (wbAddrLow)
    );

    // one aligner and one extractor per slot
    for (genvar i = 0; i < numSlots; i++) begin : genSlot
        // byte address split, top bits beyond the RAM are dropped
        assign addrLow[i]  = addr[i][offsetWidth-1:0];
        assign wordAddr[i] = addr[i][addrWidth+offsetWidth-1:offsetWidth];

        storeAlign align_i (
            .storeData (storeData[i]),
            .size      (size[i]),
            .addrLow   (addrLow[i]),
            .laneData  (laneData[i]),
            .strobe    (alignedStrobe[i])
        );

        loadExtract extract_i (
            .readData   (readData[i]),
            .size       (wbSize[i]),
            .addrLow    (wbAddrLow[i]),
            .loadSigned (wbSigned[i]),
            .loadData   (wbData[i])
        );
    end

    dataRam #(
        .addrWidth (addrWidth)
    ) ram_i (
        .clk       (clk),
        .reqValid  (reqValid),
        .reqWrite  (reqWrite),
        .wordAddr  (wordAddr),
        .writeData (laneData),
        .strobe    (reqStrobe),
        .readData  (readData)
    );

endmodule

/* verification/memStage_assert.sv */
`timescale 1ns/100ps

module memStageAssert (
    input  logic                                                    clk,
    input  logic                                                    rstN,
    input  logic [pipeDefsPkg::numSlots-1:0]                        slotValid,
    input  pipeDefsPkg::ctlClass_t [pipeDefsPkg::numSlots-1:0]      ctl,
    input  logic [pipeDefsPkg::numSlots-1:0]                        reqValid,
    input  logic [pipeDefsPkg::numSlots-1:0]                        reqWrite,
    input  logic [pipeDefsPkg::numSlots-1:0]                        wbValid
);

    import pipeDefsPkg::*;

    // sampled on the falling edge, after the reset edge has settled
    wbQuietInReset: assert property (@(negedge clk) !rstN |-> (wbValid == '0))
        else $error("wbValid set during reset");

    // younger slot stays off the RAM behind a trapping older slot
    squashYounger: assert property (@(posedge clk) disable iff (!rstN)
        (slotValid[1] && (ctl[1] == ctlException || ctl[1] == ctlEret)) |-> !reqValid[0])
        else $error("slot 0 request behind a trapping slot 1");

    // writeback only for a load issued one cycle before
    for (genvar i = 0; i < numSlots; i++) begin : genWb
        wbAfterLoad: assert property (@(posedge clk) disable iff (!rstN)
            wbValid[i] |-> $past(reqValid[i] && !reqWrite[i]))
            else $error("wbValid without a load request on slot %0d", i);
    end

endmodule

bind memStage memStageAssert stageAssert_i (
    .clk       (clk),
    .rstN      (rstN),
    .slotValid (slotValid),
    .ctl       (ctl),
    .reqValid  (reqValid),
    .reqWrite  (reqWrite),
    .wbValid   (wbValid)
);

/* verification/tbMemSubsystem.sv */
`timescale 1ns/100ps

module tbMemSubsystem;

    import pipeDefsPkg::*;
    import busDefsPkg::*;

    // 32 words cover every address used below
    localparam int addrWidth = 5;
    localparam int memBytes = 4 * (2 ** addrWidth);
    localparam int clkPeriod = 40;
    localparam int resetCycles = 2;
    // slack for reset release and the final writeback
    localparam int marginCycles = 20;
    localparam logic [15:0] lfsrSeed = 16'd55480;

    // one slot of a table entry
    typedef struct packed {
        logic                   valid;
        logic                   ld;
        logic                   st;
        logic                   sgn;
        accessSize_t            size;
        word_t                  addr;
        word_t                  data;
        // store data drawn from the lfsr when applied
        logic                   rnd;
        logic [regIdxWidth-1:0] rdst;
        ctlClass_t              ctl;
    } slotCmd_t;

    // slot 1 is older than slot 0
    typedef struct packed {
        slotCmd_t older;
        slotCmd_t younger;
        logic     expExcp;
    } pairCmd_t;

    logic clk = 1'b0;
    logic rstN = 1'b0;

    logic [numSlots-1:0]                  slotValid;
    logic [numSlots-1:0]                  isLoad;
    logic [numSlots-1:0]                  isStore;
    logic [numSlots-1:0]                  loadSigned;
    accessSize_t [numSlots-1:0]           size;
    word_t [numSlots-1:0]                 addr;
    word_t [numSlots-1:0]                 storeData;
    logic [numSlots-1:0][regIdxWidth-1:0] rdst;
    ctlClass_t [numSlots-1:0]             ctl;
    logic                                 excp;
    logic [numSlots-1:0]                  wbValid;
    logic [numSlots-1:0][regIdxWidth-1:0] wbRdst;
    word_t [numSlots-1:0]                 wbData;

    // byte-wide reference copy of the RAM
    logic [7:0] refMem [memBytes];
    pairCmd_t stimTable [$];
    logic tableReady = 1'b0;
    logic [15:0] lfsrState;

    // writeback owed by the previous pair
    logic [numSlots-1:0]   expWbValid = '0;
    logic [regIdxWidth-1:0] expWbRdst [numSlots];
    word_t                 expWbData [numSlots];

    memSubsystem #(
        .addrWidth (addrWidth)
    ) dut_i (
        .clk        (clk),
        .rstN       (rstN),
        .slotValid  (slotValid),
        .isLoad     (isLoad),
        .isStore    (isStore),
        .loadSigned (loadSigned),
        .size       (size),
        .addr       (addr),
        .storeData  (storeData),
        .rdst       (rdst),
        .ctl        (ctl),
        .excp       (excp),
        .wbValid    (wbValid),
        .wbRdst     (wbRdst),
        .wbData     (wbData)
    );

    initial begin
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // 16-bit galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] galoisStep(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    // one lfsr step per bit
    function automatic word_t randWord();
        word_t w;
        int k;
        w = '0;
        for (k = 0; k < 32; k++) begin
            lfsrState = galoisStep(lfsrState);
            w = {w[30:0], lfsrState[0]};
        end
        return w;
    endfunction

    function automatic int accessBytes(input accessSize_t sz);
        case (sz)
            sizeByte: return 1;
            sizeHalf: return 2;
            default:  return 4;
        endcase
    endfunction

    // valid plain-class slot with random data for stores
    function automatic slotCmd_t makeCmd(input logic ld, input logic st,
                                         input word_t a, input accessSize_t sz);
        slotCmd_t c;
        c.valid = 1'b1;
        c.ld    = ld;
        c.st    = st;
        c.sgn   = 1'b0;
        c.size  = sz;
        c.addr  = a;
        c.data  = '0;
        c.rnd   = st;
        c.rdst  = '0;
        c.ctl   = ctlNone;
        return c;
    endfunction

    function automatic slotCmd_t idleCmd();
        slotCmd_t c;
        c = makeCmd(1'b0, 1'b0, '0, sizeWord);
        c.valid = 1'b0;
        return c;
    endfunction

    function automatic slotCmd_t loadCmd(input word_t a, input accessSize_t sz,
                                         input logic sgn, input int rd);
        slotCmd_t c;
        c = makeCmd(1'b1, 1'b0, a, sz);
        c.sgn  = sgn;
        c.rdst = rd[regIdxWidth-1:0];
        return c;
    endfunction

    function automatic slotCmd_t storeCmd(input word_t a, input accessSize_t sz,
                                          input word_t d);
        slotCmd_t c;
        c = makeCmd(1'b0, 1'b1, a, sz);
        c.data = d;
        c.rnd  = 1'b0;
        return c;
    endfunction

    function automatic slotCmd_t storeRandCmd(input word_t a, input accessSize_t sz);
        return makeCmd(1'b0, 1'b1, a, sz);
    endfunction

    // trapping slot that also carries a word store the RAM must not see
    function automatic slotCmd_t trapCmd(input ctlClass_t cls, input word_t a);
        slotCmd_t c;
        c = makeCmd(1'b0, 1'b1, a, sizeWord);
        c.ctl = cls;
        return c;
    endfunction

    // low data bytes go to the addressed bytes in little-endian order
    task automatic modelStore(input slotCmd_t c);
        int base;
        int k;
        base = c.addr % memBytes;
        for (k = 0; k < accessBytes(c.size); k++) begin
            refMem[base+k] = c.data[8*k +: 8];
        end
    endtask

    function automatic word_t predictLoad(input slotCmd_t c);
        word_t v;
        int base;
        int n;
        int k;
        base = c.addr % memBytes;
        n = accessBytes(c.size);
        v = '0;
        for (k = 0; k < n; k++) begin
            v[8*k +: 8] = refMem[base+k];
        end
        // lb and lh copy the top loaded bit upward
        if (c.sgn && n < 4 && v[8*n-1]) begin
            for (k = n; k < 4; k++) begin
                v[8*k +: 8] = 8'hFF;
            end
        end
        return v;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic driveSlot(input int i, input slotCmd_t c);
        slotValid[i]  = c.valid;
        isLoad[i]     = c.ld;
        isStore[i]    = c.st;
        loadSigned[i] = c.sgn;
        size[i]       = c.size;
        addr[i]       = c.addr;
        storeData[i]  = c.data;
        rdst[i]       = c.rdst;
        ctl[i]        = c.ctl;
    endtask

    task automatic checkWriteback();
        int i;
        for (i = 0; i < numSlots; i++) begin
            checkValue($sformatf("wbValid[%0d]", i), wbValid[i], expWbValid[i]);
            if (expWbValid[i]) begin
                checkValue($sformatf("wbRdst[%0d]", i), wbRdst[i], expWbRdst[i]);
                checkValue($sformatf("wbData[%0d]", i), wbData[i], expWbData[i]);
            end
        end
    endtask

    task automatic applyPair(input pairCmd_t e);
        slotCmd_t cmd [numSlots];
        logic [numSlots-1:0] live;
        int i;
        cmd[1] = e.older;
        cmd[0] = e.younger;
        @(negedge clk);
        // last pair's load results are due now
        checkWriteback();
        for (i = numSlots - 1; i >= 0; i--) begin
            if (cmd[i].rnd) begin
                cmd[i].data = randWord();
            end
            driveSlot(i, cmd[i]);
        end
        // a trapping older slot kills the younger one
        live[1] = cmd[1].valid && cmd[1].ctl == ctlNone;
        live[0] = cmd[0].valid && cmd[0].ctl == ctlNone &&
                  !(cmd[1].valid && cmd[1].ctl != ctlNone);
        // loads see memory from before this edge
        for (i = 0; i < numSlots; i++) begin
            expWbValid[i] = live[i] && cmd[i].ld && !cmd[i].st;
            expWbRdst[i]  = cmd[i].rdst;
            expWbData[i]  = predictLoad(cmd[i]);
        end
        // older first so the younger bytes end up on top
        for (i = numSlots - 1; i >= 0; i--) begin
            if (live[i] && cmd[i].st) begin
                modelStore(cmd[i]);
            end
        end
        @(posedge clk);
        checkValue("excp", excp, e.expExcp);
    endtask

    task automatic addEntry(input slotCmd_t older, input slotCmd_t younger,
                            input logic expExcp);
        pairCmd_t e;
        e.older   = older;
        e.younger = younger;
        e.expExcp = expExcp;
        stimTable.push_back(e);
    endtask

    task automatic buildStimulus();
        int w;
        // fill every word two per cycle
        for (w = 0; w < memBytes / 8; w++) begin
            addEntry(storeRandCmd(8 * w, sizeWord), storeRandCmd(8 * w + 4, sizeWord), 1'b0);
        end
        // lane placement and strobes
        addEntry(storeRandCmd(32'h00, sizeWord), storeRandCmd(32'h04, sizeHalf), 1'b0);
        addEntry(storeRandCmd(32'h06, sizeHalf), storeRandCmd(32'h08, sizeByte), 1'b0);
        addEntry(storeRandCmd(32'h09, sizeByte), storeRandCmd(32'h0A, sizeByte), 1'b0);
        addEntry(storeRandCmd(32'h0B, sizeByte), loadCmd(32'h00, sizeWord, 1'b0, 1), 1'b0);
        addEntry(loadCmd(32'h04, sizeWord, 1'b0, 2), loadCmd(32'h08, sizeWord, 1'b0, 3), 1'b0);
        // extension with bytes 80 7f 7f 80 from the bottom up
        addEntry(storeCmd(32'h10, sizeWord, 32'h807F7F80), idleCmd(), 1'b0);
        addEntry(loadCmd(32'h10, sizeByte, 1'b1, 4), loadCmd(32'h10, sizeByte, 1'b0, 5), 1'b0);
        addEntry(loadCmd(32'h11, sizeByte, 1'b1, 6), loadCmd(32'h13, sizeByte, 1'b0, 7), 1'b0);
        addEntry(loadCmd(32'h13, sizeByte, 1'b1, 8), loadCmd(32'h12, sizeHalf, 1'b1, 9), 1'b0);
        addEntry(loadCmd(32'h10, sizeHalf, 1'b1, 10), loadCmd(32'h12, sizeHalf, 1'b0, 11), 1'b0);
        addEntry(loadCmd(32'h10, sizeHalf, 1'b0, 12), loadCmd(32'h12, sizeByte, 1'b0, 13), 1'b0);
        // same word from both slots
        addEntry(storeRandCmd(32'h20, sizeWord), storeRandCmd(32'h21, sizeByte), 1'b0);
        addEntry(loadCmd(32'h20, sizeWord, 1'b0, 28), idleCmd(), 1'b0);
        addEntry(storeRandCmd(32'h22, sizeHalf), storeRandCmd(32'h20, sizeWord), 1'b0);
        addEntry(loadCmd(32'h20, sizeWord, 1'b0, 14), idleCmd(), 1'b0);
        addEntry(storeRandCmd(32'h24, sizeWord), loadCmd(32'h24, sizeWord, 1'b0, 15), 1'b0);
        addEntry(loadCmd(32'h24, sizeWord, 1'b0, 16), idleCmd(), 1'b0);
        // older slot traps
        addEntry(trapCmd(ctlException, 32'h38), storeRandCmd(32'h28, sizeWord), 1'b1);
        addEntry(trapCmd(ctlEret, 32'h3C), loadCmd(32'h28, sizeWord, 1'b0, 17), 1'b1);
        addEntry(loadCmd(32'h28, sizeWord, 1'b0, 18), idleCmd(), 1'b0);
        // younger slot traps alone
        addEntry(storeRandCmd(32'h2C, sizeWord), trapCmd(ctlException, 32'h34), 1'b1);
        addEntry(loadCmd(32'h30, sizeWord, 1'b0, 19), trapCmd(ctlEret, 32'h38), 1'b1);
        // back-to-back load pairs
        addEntry(loadCmd(32'h2C, sizeWord, 1'b0, 20), loadCmd(32'h34, sizeWord, 1'b0, 21), 1'b0);
        addEntry(loadCmd(32'h38, sizeWord, 1'b0, 22), loadCmd(32'h3C, sizeWord, 1'b0, 23), 1'b0);
        addEntry(loadCmd(32'h40, sizeWord, 1'b0, 24), loadCmd(32'h46, sizeHalf, 1'b1, 25), 1'b0);
        addEntry(loadCmd(32'h7C, sizeWord, 1'b0, 26), loadCmd(32'h05, sizeByte, 1'b1, 27), 1'b0);
        // drains the last writeback
        addEntry(idleCmd(), idleCmd(), 1'b0);
    endtask

    initial begin
        for (int i = 0; i < numSlots; i++) begin
            driveSlot(i, idleCmd());
        end
        lfsrState = lfsrSeed;
        buildStimulus();
        tableReady = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        foreach (stimTable[n]) begin
            applyPair(stimTable[n]);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    // bound on run time from the table length
    initial begin
        wait (tableReady);
        #((stimTable.size() + resetCycles + marginCycles) * clkPeriod);
        $display("watchdog expired, the run hung before the stimulus table finished");
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

endmodule

/* vlog.f */
hw/pipeDefsPkg.sv
hw/busDefsPkg.sv
hw/storeAlign.sv
hw/loadExtract.sv
hw/dataRam.sv
hw/memStage.sv
hw/memSubsystem.sv
verification/memStage_assert.sv
verification/tbMemSubsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  # packages first, the stage modules import them
  - hw/pipeDefsPkg.sv
  - hw/busDefsPkg.sv
  # leaf blocks
  - hw/storeAlign.sv
  - hw/loadExtract.sv
  - hw/dataRam.sv
  - hw/memStage.sv
  # top level
  - hw/memSubsystem.sv
  # testbench and bound assertions
  - target: test
    files:
      - verification/memStage_assert.sv
      - verification/tbMemSubsystem.sv
